// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_trace_sniffer
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/event_recorder.sv
// match event recorder
// free-running timestamp; each match cycle stores the lowest matching
// rule and its timestamp in an 8-entry FIFO read out over valid/ready.
// a match that finds the FIFO full is dropped and sets a sticky overflow
`timescale 1ns/1ps
`default_nettype none

module event_recorder (
  input  wire                                        fe_clk,
  input  wire                                        reset,
  input  trace_cfg_pkg::rule_vec_t                   match,
  input  wire                                        arm_pulse,
  output logic                                       ev_valid,
  input  wire                                        ev_ready,
  output logic [trace_cfg_pkg::RULE_IDX_WIDTH-1:0]   ev_rule,
  output trace_cfg_pkg::timestamp_t                  ev_time,
  output logic                                       overflow
);

  import trace_cfg_pkg::*;

  localparam int PTR_WIDTH = $clog2(EVENT_FIFO_DEPTH);

  timestamp_t                timestamp;
  event_t                    fifo_mem [EVENT_FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]      wr_ptr;
  logic [PTR_WIDTH-1:0]      rd_ptr;
  logic [PTR_WIDTH:0]        fill;
  logic [RULE_IDX_WIDTH-1:0] first_rule;
  logic                      full;
  logic                      push;
  logic                      pop;

  // scan from the top so the lowest index wins
  always_comb begin
    first_rule = '0;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if (match[i])
        first_rule = RULE_IDX_WIDTH'(i);
    end
  end

  assign full     = fill == EVENT_FIFO_DEPTH;
  assign push     = |match && !full;
  assign ev_valid = fill != '0;
  assign pop      = ev_valid && ev_ready;
  assign ev_rule  = fifo_mem[rd_ptr].rule;
  assign ev_time  = fifo_mem[rd_ptr].ts;

  always_ff @(posedge fe_clk) begin
    if (push)
      fifo_mem[wr_ptr] <= '{rule: first_rule, ts: timestamp};
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      timestamp <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      overflow  <= 1'b0;
    end else begin
      timestamp <= timestamp + 1'b1;   // edges since reset
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      if (arm_pulse)
        overflow <= 1'b0;
      if (|match && full)
        overflow <= 1'b1;   // dropped event
    end
  end

endmodule

`default_nettype wire

// File: hw/trace_cfg_pkg.sv
// trace sniffer configuration package
// sizes of the rule set, trace buffer, counters and event records,
// plus the types built from them
`default_nettype none

package trace_cfg_pkg;

  localparam int NUM_RULES        = 4;
  localparam int RULE_IDX_WIDTH   = 2;
  localparam int PATTERN_BYTES    = 4;   // bytes held in the shift buffer
  localparam int PATTERN_BITS     = 32;
  localparam int COUNT_WIDTH      = 8;   // saturating match counters
  localparam int NUM_TRIG_WIDTH   = 4;
  localparam int TS_WIDTH         = 16;
  localparam int EVENT_FIFO_DEPTH = 8;

  typedef logic [7:0] trace_byte_t;

  // pattern and mask share one type
  typedef logic [PATTERN_BITS-1:0] pattern_t;

  typedef logic [NUM_RULES-1:0] rule_vec_t;   // one bit per rule

  typedef logic [COUNT_WIDTH-1:0] match_count_t;

  typedef logic [NUM_TRIG_WIDTH-1:0] trig_count_t;

  typedef logic [TS_WIDTH-1:0] timestamp_t;

  // one recorded match, 18 bits
  typedef struct packed {
    logic [RULE_IDX_WIDTH-1:0] rule;
    timestamp_t                ts;
  } event_t;

endpackage

`default_nettype wire

// File: hw/trace_matcher.sv
// trace pattern matcher
// shifts valid trace bytes into a 4-byte buffer, compares it against the
// masked rules and registers a one-cycle match vector; each rule keeps
// a saturating count of its matches
`timescale 1ns/1ps
`default_nettype none

module trace_matcher (
  input  wire                                                      fe_clk,
  input  wire                                                      reset,
  input  trace_cfg_pkg::trace_byte_t                               trace_data,
  input  wire                                                      trace_valid,
  input  trace_cfg_pkg::rule_vec_t                                 rule_enable,
  input  trace_cfg_pkg::pattern_t [trace_cfg_pkg::NUM_RULES-1:0]   patterns,
  input  trace_cfg_pkg::pattern_t [trace_cfg_pkg::NUM_RULES-1:0]   masks,
  output trace_cfg_pkg::rule_vec_t                                 match,
  output trace_cfg_pkg::match_count_t [trace_cfg_pkg::NUM_RULES-1:0] match_counts
);

  import trace_cfg_pkg::*;

  pattern_t  shift_buf;
  logic      buf_new;    // buffer took a byte last edge
  rule_vec_t hits;

  always_comb begin
    for (int i = 0; i < NUM_RULES; i++) begin
      hits[i] = rule_enable[i] && (((shift_buf ^ patterns[i]) & masks[i]) == '0);
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      shift_buf <= '0;
      buf_new   <= 1'b0;
      match     <= '0;
    end else begin
      if (trace_valid)
        shift_buf <= {shift_buf[PATTERN_BITS-9:0], trace_data};  // newest in low byte
      buf_new <= trace_valid;
      match   <= buf_new ? hits : '0;   // only compare a fresh buffer
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      match_counts <= '0;
    end else begin
      for (int i = 0; i < NUM_RULES; i++) begin
        if (match[i] && (match_counts[i] != {COUNT_WIDTH{1'b1}}))
          match_counts[i] <= match_counts[i] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/trace_regmap_pkg.sv
// register map of the byte-wide control bus
// addresses and bit positions used by the register file
`default_nettype none

package trace_regmap_pkg;

  localparam logic [7:0] REG_CTRL             = 8'h00;
  localparam logic [7:0] REG_ARM              = 8'h01;  // write only
  localparam logic [7:0] REG_NUM_TRIGGERS     = 8'h02;
  localparam logic [7:0] REG_RULE_ENABLE      = 8'h03;
  localparam logic [7:0] REG_TRIG_RULE_ENABLE = 8'h04;
  localparam logic [7:0] REG_STATUS           = 8'h05;  // read only

  // 16-byte aligned blocks, rule * 4 + byte
  localparam logic [7:0] REG_PATTERN_BASE     = 8'h10;
  localparam logic [7:0] REG_MASK_BASE        = 8'h20;
  localparam logic [7:0] REG_COUNT_BASE       = 8'h30;  // one byte per rule

  localparam int CTRL_TRIG_EN_BIT    = 0;
  localparam int STATUS_OVERFLOW_BIT = 6;
  localparam int STATUS_ARMED_BIT    = 7;

endpackage

`default_nettype wire

// File: hw/trace_regs.sv
// trace sniffer register file
// holds rule patterns, masks, enables and trigger setup written over the
// byte bus; a write to the arm register gives a one-cycle arm pulse.
// reads are registered and pick up counts and status
`timescale 1ns/1ps
`default_nettype none

module trace_regs (
  input  wire                                                   fe_clk,
  input  wire                                                   reset,
  input  wire                                                   reg_write,
  input  wire                                                   reg_read,
  input  wire [7:0]                                             reg_address,
  input  wire [7:0]                                             write_data,
  output logic [7:0]                                            read_data,
  output trace_cfg_pkg::rule_vec_t                              rule_enable,
  output trace_cfg_pkg::rule_vec_t                              trig_rule_enable,
  output logic                                                  trig_enable,
  output trace_cfg_pkg::trig_count_t                            num_triggers,
  output logic                                                  arm_pulse,
  output trace_cfg_pkg::pattern_t [trace_cfg_pkg::NUM_RULES-1:0] patterns,
  output trace_cfg_pkg::pattern_t [trace_cfg_pkg::NUM_RULES-1:0] masks,
  input  trace_cfg_pkg::match_count_t [trace_cfg_pkg::NUM_RULES-1:0] match_counts,
  input  trace_cfg_pkg::trig_count_t                            triggers_generated,
  input  wire                                                   armed,
  input  wire                                                   overflow
);

  import trace_cfg_pkg::*;
  import trace_regmap_pkg::*;

  logic                               in_pattern;
  logic                               in_mask;
  logic                               in_count;
  logic [RULE_IDX_WIDTH-1:0]          rule_sel;
  logic [$clog2(PATTERN_BYTES)-1:0]   lane_sel;
  logic [RULE_IDX_WIDTH-1:0]          count_sel;
  logic [7:0]                         rd_value;

  // pattern and mask blocks are aligned, so the low nibble is rule/lane
  assign in_pattern = reg_address[7:4] == REG_PATTERN_BASE[7:4];
  assign in_mask    = reg_address[7:4] == REG_MASK_BASE[7:4];
  assign in_count   = reg_address[7:RULE_IDX_WIDTH] == REG_COUNT_BASE[7:RULE_IDX_WIDTH];
  assign rule_sel   = reg_address[3:2];
  assign lane_sel   = reg_address[1:0];
  assign count_sel  = reg_address[RULE_IDX_WIDTH-1:0];

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      trig_enable      <= 1'b0;
      num_triggers     <= '0;
      rule_enable      <= '0;
      trig_rule_enable <= '0;
      patterns         <= '0;
      masks            <= '0;
      arm_pulse        <= 1'b0;
    end else begin
      arm_pulse <= reg_write && (reg_address == REG_ARM);  // any data value arms
      if (reg_write) begin
        case (reg_address)
          REG_CTRL:             trig_enable      <= write_data[CTRL_TRIG_EN_BIT];
          REG_NUM_TRIGGERS:     num_triggers     <= write_data[NUM_TRIG_WIDTH-1:0];
          REG_RULE_ENABLE:      rule_enable      <= write_data[NUM_RULES-1:0];
          REG_TRIG_RULE_ENABLE: trig_rule_enable <= write_data[NUM_RULES-1:0];
          default: begin
            if (in_pattern)
              patterns[rule_sel][lane_sel*8 +: 8] <= write_data;
            else if (in_mask)
              masks[rule_sel][lane_sel*8 +: 8] <= write_data;
          end
        endcase
      end
    end
  end

  // readback value, unmapped reads as zero
  always_comb begin
    rd_value = '0;
    case (reg_address)
      REG_CTRL:             rd_value[CTRL_TRIG_EN_BIT] = trig_enable;
      REG_NUM_TRIGGERS:     rd_value[NUM_TRIG_WIDTH-1:0] = num_triggers;
      REG_RULE_ENABLE:      rd_value[NUM_RULES-1:0] = rule_enable;
      REG_TRIG_RULE_ENABLE: rd_value[NUM_RULES-1:0] = trig_rule_enable;
      REG_STATUS: begin
        rd_value[NUM_TRIG_WIDTH-1:0]  = triggers_generated;
        rd_value[STATUS_OVERFLOW_BIT] = overflow;
        rd_value[STATUS_ARMED_BIT]    = armed;
      end
      default: begin
        if (in_pattern)
          rd_value = patterns[rule_sel][lane_sel*8 +: 8];
        else if (in_mask)
          rd_value = masks[rule_sel][lane_sel*8 +: 8];
        else if (in_count)
          rd_value = match_counts[count_sel];
      end
    endcase
  end

  always_ff @(posedge fe_clk) begin
    if (reset)
      read_data <= '0;
    else if (reg_read)
      read_data <= rd_value;   // holds until next read
  end

endmodule

`default_nettype wire

// File: hw/trace_sniffer_top.sv
// trace byte sniffer, top level
// register file, pattern matcher, trigger generator and event recorder
// on the single fe_clk domain
`timescale 1ns/1ps
`default_nettype none

module trace_sniffer_top (
  input  wire                                       fe_clk,
  input  wire                                       reset,
  input  wire                                       reg_write,
  input  wire                                       reg_read,
  input  wire [7:0]                                 reg_address,
  input  wire [7:0]                                 write_data,
  output logic [7:0]                                read_data,
  input  trace_cfg_pkg::trace_byte_t                trace_data,
  input  wire                                       trace_valid,
  output logic                                      trig_out,
  output logic                                      ev_valid,
  input  wire                                       ev_ready,
  output logic [trace_cfg_pkg::RULE_IDX_WIDTH-1:0]  ev_rule,
  output trace_cfg_pkg::timestamp_t                 ev_time
);

  import trace_cfg_pkg::*;

  rule_vec_t                      rule_enable;
  rule_vec_t                      trig_rule_enable;
  logic                           trig_enable;
  trig_count_t                    num_triggers;
  logic                           arm_pulse;
  pattern_t [NUM_RULES-1:0]       patterns;
  pattern_t [NUM_RULES-1:0]       masks;
  match_count_t [NUM_RULES-1:0]   match_counts;
  trig_count_t                    triggers_generated;
  logic                           armed;
  logic                           overflow;
  rule_vec_t                      match;

  trace_regs u_trace_regs (
    .fe_clk             (fe_clk),
    .reset              (reset),
    .reg_write          (reg_write),
    .reg_read           (reg_read),
    .reg_address        (reg_address),
    .write_data         (write_data),
    .read_data          (read_data),
    .rule_enable        (rule_enable),
    .trig_rule_enable   (trig_rule_enable),
    .trig_enable        (trig_enable),
    .num_triggers       (num_triggers),
    .arm_pulse          (arm_pulse),
    .patterns           (patterns),
    .masks              (masks),
    .match_counts       (match_counts),
    .triggers_generated (triggers_generated),
    .armed              (armed),
    .overflow           (overflow)
  );

  trace_matcher u_trace_matcher (
    .fe_clk       (fe_clk),
    .reset        (reset),
    .trace_data   (trace_data),
    .trace_valid  (trace_valid),
    .rule_enable  (rule_enable),
    .patterns     (patterns),
    .masks        (masks),
    .match        (match),
    .match_counts (match_counts)
  );

  trace_trigger u_trace_trigger (
    .fe_clk             (fe_clk),
    .reset              (reset),
    .arm_pulse          (arm_pulse),
    .trig_enable        (trig_enable),
    .trig_rule_enable   (trig_rule_enable),
    .num_triggers       (num_triggers),
    .match              (match),
    .trig_out           (trig_out),
    .triggers_generated (triggers_generated),
    .armed              (armed)
  );

  event_recorder u_event_recorder (
    .fe_clk    (fe_clk),
    .reset     (reset),
    .match     (match),
    .arm_pulse (arm_pulse),
    .ev_valid  (ev_valid),
    .ev_ready  (ev_ready),
    .ev_rule   (ev_rule),
    .ev_time   (ev_time),
    .overflow  (overflow)
  );

endmodule

`default_nettype wire

// File: hw/trace_trigger.sv
// trigger generator
// once armed, each match on a trigger-enabled rule gives a one-cycle
// trigger pulse until the programmed number of pulses is reached
`timescale 1ns/1ps
`default_nettype none

module trace_trigger (
  input  wire                         fe_clk,
  input  wire                         reset,
  input  wire                         arm_pulse,
  input  wire                         trig_enable,
  input  trace_cfg_pkg::rule_vec_t    trig_rule_enable,
  input  trace_cfg_pkg::trig_count_t  num_triggers,
  input  trace_cfg_pkg::rule_vec_t    match,
  output logic                        trig_out,
  output trace_cfg_pkg::trig_count_t  triggers_generated,
  output logic                        armed
);

  import trace_cfg_pkg::*;

  logic        fire;
  trig_count_t next_count;

  assign fire       = armed && trig_enable && |(match & trig_rule_enable);
  assign next_count = triggers_generated + 1'b1;

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      trig_out           <= 1'b0;
      triggers_generated <= '0;
      armed              <= 1'b0;
    end else begin
      trig_out <= fire && !arm_pulse;
      if (arm_pulse) begin
        triggers_generated <= '0;
        armed              <= num_triggers != '0;  // zero pulses means stay idle
      end else if (fire) begin
        triggers_generated <= next_count;
        if (next_count == num_triggers)
          armed <= 1'b0;   // last pulse
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_tasks.svh
// testbench helpers for the trace sniffer
// register bus access, trace stream driving with the reference model
// of the shift buffer and rule compare, and per-test bookkeeping

  int errors          = 0;
  int errors_at_start = 0;
  int tests_run       = 0;
  int tests_failed    = 0;

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    @(posedge fe_clk);
    reg_write   <= 1'b1;
    reg_address <= addr;
    write_data  <= data;
    @(posedge fe_clk);
    reg_write <= 1'b0;
  endtask

  // read data shows up one cycle after the read is sampled
  task automatic check_reg(input logic [7:0] addr, input logic [7:0] want,
                           input string what);
    logic [7:0] got;
    @(posedge fe_clk);
    reg_read    <= 1'b1;
    reg_address <= addr;
    @(posedge fe_clk);
    reg_read <= 1'b0;
    @(posedge fe_clk);
    got = read_data;
    assert (got == want) else begin
      $display("MISMATCH at %0t: %s at 0x%02h read 0x%02h, expected 0x%02h",
               $time, what, addr, got, want);
      errors++;
    end
  endtask

  task automatic set_rule(input int r, input pattern_t pat, input pattern_t mask);
    for (int b = 0; b < PATTERN_BYTES; b++) begin
      write_reg(REG_PATTERN_BASE + 8'(r * 4 + b), pat[b*8 +: 8]);
      write_reg(REG_MASK_BASE + 8'(r * 4 + b), mask[b*8 +: 8]);
    end
    model_pat[r]  = pat;
    model_mask[r] = mask;
  endtask

  task automatic set_rule_enable(input rule_vec_t en);
    write_reg(REG_RULE_ENABLE, 8'(en));
    model_en = en;
  endtask

  // one trace byte, plus the model's view of what it completes
  task automatic send_byte(input trace_byte_t b);
    rule_vec_t hits;
    int        first;
    @(posedge fe_clk);
    trace_valid <= 1'b1;
    trace_data  <= b;
    model_buf = {model_buf[PATTERN_BITS-9:0], b};   // newest byte at the bottom
    first = -1;
    for (int r = 0; r < NUM_RULES; r++) begin
      hits[r] = model_en[r] &&
                ((model_buf & model_mask[r]) == (model_pat[r] & model_mask[r]));
      if (hits[r] && model_count[r] < 255)
        model_count[r]++;
      if (hits[r] && first < 0)
        first = r;
    end
    // a full FIFO in the model drops the event
    if (first >= 0 && exp_rule_q.size() < EVENT_FIFO_DEPTH) begin
      exp_rule_q.push_back(first);
      exp_time_q.push_back($time);
    end
  endtask

  // plant a rule's pattern, masked-out bits random
  task automatic plant_rule(input int r);
    pattern_t word;
    word = (model_pat[r] & model_mask[r]) | ($random(seed) & ~model_mask[r]);
    for (int b = PATTERN_BYTES - 1; b >= 0; b--)
      send_byte(word[b*8 +: 8]);
  endtask

  task automatic stream_idle(input int n);
    @(posedge fe_clk);
    trace_valid <= 1'b0;
    repeat (n) @(posedge fe_clk);
  endtask

  task automatic wait_drained();
    while (exp_rule_q.size() != 0)
      @(posedge fe_clk);
  endtask

  task automatic check_counts();
    for (int r = 0; r < NUM_RULES; r++)
      check_reg(REG_COUNT_BASE + 8'(r), 8'(model_count[r]), "match count");
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

// File: testbench/tb_trace_sniffer.sv
// testbench for the trace byte sniffer
// drives the register bus and the trace stream, keeps its own model of
// the shift buffer and rule compare, and checks readback, counts, the
// event stream, trigger pulses and FIFO overflow
`timescale 1ns/1ps
`default_nettype none

module tb_trace_sniffer;

  import trace_cfg_pkg::*;
  import trace_regmap_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int MAX_CYCLES = 4000;   // tests need about 1500

  logic                      fe_clk = 1'b0;
  logic                      reset;
  logic                      reg_write;
  logic                      reg_read;
  logic [7:0]                reg_address;
  logic [7:0]                write_data;
  logic [7:0]                read_data;
  trace_byte_t               trace_data;
  logic                      trace_valid;
  logic                      trig_out;
  logic                      ev_valid;
  logic                      ev_ready;
  logic [RULE_IDX_WIDTH-1:0] ev_rule;
  timestamp_t                ev_time;

  // reference model
  pattern_t   model_buf;
  pattern_t   model_pat [NUM_RULES];
  pattern_t   model_mask [NUM_RULES];
  rule_vec_t  model_en;
  int         model_count [NUM_RULES];
  int         exp_rule_q [$];
  longint     exp_time_q [$];

  int         seed = 32'hb961;
  int         ready_seed = 32'hb961;   // own stream for ev_ready
  int         ready_rnd;
  int         ready_mode;              // 0 high, 1 random, 2 low
  int         cycles = 0;
  int         trig_pulses = 0;
  int         seen_events = 0;
  int         events_before;
  int         exp_rule;
  longint     exp_time;
  longint     last_time;
  timestamp_t last_ev_time;
  logic [7:0] cfg_val [4];
  logic [7:0] cfg_addr [4] = '{REG_CTRL, REG_NUM_TRIGGERS,
                               REG_RULE_ENABLE, REG_TRIG_RULE_ENABLE};
  logic [7:0] cfg_mask [4] = '{8'h01, 8'h0f, 8'h0f, 8'h0f};   // readable bits

  `include "tb_tasks.svh"

  trace_sniffer_top dut_i (
    .fe_clk      (fe_clk),
    .reset       (reset),
    .reg_write   (reg_write),
    .reg_read    (reg_read),
    .reg_address (reg_address),
    .write_data  (write_data),
    .read_data   (read_data),
    .trace_data  (trace_data),
    .trace_valid (trace_valid),
    .trig_out    (trig_out),
    .ev_valid    (ev_valid),
    .ev_ready    (ev_ready),
    .ev_rule     (ev_rule),
    .ev_time     (ev_time)
  );

  always #(CLK_PERIOD / 2) fe_clk = ~fe_clk;

  always @(posedge fe_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped: cycle limit of %0d reached", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  always @(posedge fe_clk) begin
    ready_rnd = $random(ready_seed);
    case (ready_mode)
      1:       ev_ready <= ready_rnd[0];
      2:       ev_ready <= 1'b0;
      default: ev_ready <= 1'b1;
    endcase
  end

  always @(posedge fe_clk) begin
    if (trig_out)
      trig_pulses++;
  end

  // event checker, order and timestamp spacing against the model
  always @(posedge fe_clk) begin
    if (!reset && ev_valid && ev_ready) begin
      if (exp_rule_q.size() == 0) begin
        $display("event from rule %0d arrived with no match expected", ev_rule);
        errors++;
      end else begin
        exp_rule = exp_rule_q.pop_front();
        exp_time = exp_time_q.pop_front();
        assert (int'(ev_rule) == exp_rule) else begin
          $display("MISMATCH at %0t: event rule %0d, expected %0d", $time, ev_rule, exp_rule);
          errors++;
        end
        if (seen_events > 0) begin
          assert (timestamp_t'(ev_time - last_ev_time) ==
                  timestamp_t'((exp_time - last_time) / CLK_PERIOD)) else begin
            $display("MISMATCH at %0t: ev_time step %0d, expected %0d", $time,
                     timestamp_t'(ev_time - last_ev_time), (exp_time - last_time) / CLK_PERIOD);
            errors++;
          end
        end
        last_ev_time = ev_time;
        last_time    = exp_time;
        seen_events++;
      end
    end
  end

  // a stalled event holds until taken
  assert property (@(posedge fe_clk) disable iff (reset)
                   ev_valid && !ev_ready |=> ev_valid && $stable(ev_rule) && $stable(ev_time))
  else begin
    $display("MISMATCH at %0t: event changed while stalled", $time);
    errors++;
  end

  initial begin
    reset       = 1'b1;
    reg_write   = 1'b0;
    reg_read    = 1'b0;
    reg_address = '0;
    write_data  = '0;
    trace_data  = '0;
    trace_valid = 1'b0;
    ev_ready    = 1'b1;
    ready_mode  = 0;
    model_buf   = '0;
    model_en    = '0;
    for (int r = 0; r < NUM_RULES; r++) begin
      model_pat[r]   = '0;
      model_mask[r]  = '0;
      model_count[r] = 0;
    end
    repeat (3) @(posedge fe_clk);
    reset <= 1'b0;

    // register readback
    for (int r = 0; r < NUM_RULES; r++)
      set_rule(r, $random(seed), $random(seed));
    for (int i = 0; i < 4; i++) begin
      cfg_val[i] = 8'($random(seed));
      write_reg(cfg_addr[i], cfg_val[i]);
    end
    for (int r = 0; r < NUM_RULES; r++) begin
      for (int b = 0; b < PATTERN_BYTES; b++) begin
        check_reg(REG_PATTERN_BASE + 8'(r * 4 + b), model_pat[r][b*8 +: 8], "pattern");
        check_reg(REG_MASK_BASE + 8'(r * 4 + b), model_mask[r][b*8 +: 8], "mask");
      end
    end
    for (int i = 0; i < 4; i++)
      check_reg(cfg_addr[i], cfg_val[i] & cfg_mask[i], "control");
    check_reg(8'h34, 8'h00, "unmapped");
    check_reg(8'hc7, 8'h00, "unmapped");
    end_test("register readback");

    // masked matching, rule 3 hits every byte and saturates
    set_rule(0, 32'ha1b2c3d4, 32'hffffffff);
    set_rule(1, 32'h5a6b007c, 32'hffff00ff);
    set_rule(2, 32'h06070809, 32'h0f0f0f0f);
    set_rule(3, 32'h00000000, 32'h00000000);
    set_rule_enable(4'hf);
    for (int i = 0; i < 200; i++) begin
      send_byte(8'($random(seed)));
      if (i % 10 == 9)
        plant_rule((i / 10) % 3);
    end
    stream_idle(4);
    wait_drained();
    check_counts();
    end_test("masked matching and counts");

    // back-pressure on the event stream
    set_rule_enable(4'h7);
    ready_mode = 1;
    for (int i = 0; i < 200; i++) begin
      send_byte(8'($random(seed)));
      if (i % 12 == 11)
        plant_rule((i / 12) % 3);
    end
    stream_idle(4);
    ready_mode = 0;
    wait_drained();
    check_counts();
    end_test("event stream under back-pressure");

    // trigger fires twice on rule 1 then disarms
    write_reg(REG_NUM_TRIGGERS, 8'h02);
    write_reg(REG_TRIG_RULE_ENABLE, 8'h02);
    write_reg(REG_CTRL, 8'h01);
    write_reg(REG_ARM, 8'h00);
    trig_pulses = 0;
    repeat (3) begin
      plant_rule(1);
      stream_idle(3);
    end
    stream_idle(4);
    assert (trig_pulses == 2) else begin
      $display("MISMATCH at %0t: %0d trigger pulses, expected 2", $time, trig_pulses);
      errors++;
    end
    check_reg(REG_STATUS, 8'h02, "status after triggers");
    write_reg(REG_ARM, 8'h00);
    check_reg(REG_STATUS, 8'h80, "status after re-arm");
    wait_drained();
    end_test("trigger count");

    // ten matches into a stalled 8-deep FIFO
    ready_mode    = 2;
    events_before = seen_events;
    repeat (10) plant_rule(0);
    stream_idle(6);
    ready_mode = 0;
    wait_drained();
    stream_idle(4);
    assert (seen_events - events_before == 8) else begin
      $display("MISMATCH at %0t: %0d events after overflow, expected 8", $time,
               seen_events - events_before);
      errors++;
    end
    check_reg(REG_STATUS, 8'hc0, "status with overflow");
    write_reg(REG_ARM, 8'h00);
    check_reg(REG_STATUS, 8'h80, "status after overflow clear");
    end_test("overflow");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+testbench
hw/trace_cfg_pkg.sv
hw/trace_regmap_pkg.sv
hw/trace_regs.sv
hw/trace_matcher.sv
hw/trace_trigger.sv
hw/event_recorder.sv
hw/trace_sniffer_top.sv
testbench/tb_trace_sniffer.sv
